/* common/ntps_defines.svh */
/*
 * NTP server timing constants
 * PPS period and width, network path count, XGMII control words
 * and the index range of the beat frame data words
 */

`ifndef NTPS_DEFINES_SVH
`define NTPS_DEFINES_SVH

// --------------------------------------------------
// Internal PPS
// --------------------------------------------------
// Reference cycles per second at 10 MHz
`define NTPS_PPS_PERIOD 10_000_000
`define NTPS_PPS_WIDTH 100

// --------------------------------------------------
// Network paths and XGMII encoding
// --------------------------------------------------
`define NTPS_NUM_PATHS 4

// Lane 0 is the least significant byte
`define NTPS_XGMII_IDLE_WORD 64'h0707_0707_0707_0707
`define NTPS_XGMII_START_WORD 64'hd555_5555_5555_55fb
`define NTPS_XGMII_TERM_WORD 64'h0707_0707_0707_07fd

`define NTPS_XGMII_CTRL_ALL 8'hff
`define NTPS_XGMII_CTRL_START 8'h01
`define NTPS_XGMII_CTRL_NONE 8'h00

// --------------------------------------------------
// Beat frame
// --------------------------------------------------
// Data words carry their own index
`define NTPS_BEAT_FIRST_INDEX 2
`define NTPS_BEAT_LAST_INDEX 8

`endif

/* common/ntps_pkg.sv */
/*
 * NTP server timing types
 * Vector types for the PPS counter and the XGMII stream,
 * and the states of the beat frame FSM
 */

`default_nettype none

package ntps_pkg;

  // Second counter, also the width of the phase adjust value
  typedef logic [32:0] pps_count_t;

  // One XGMII word and its per-lane control mask
  typedef logic [63:0] xgmii_data_t;
  typedef logic [7:0]  xgmii_ctrl_t;

  // Index of a beat data word
  typedef logic [3:0]  beat_index_t;

  // --------------------------------------------------
  // Beat frame FSM
  // --------------------------------------------------
  typedef enum logic [1:0] {
    BEAT_IDLE,
    BEAT_START,
    BEAT_DATA,
    BEAT_TERM
  } beat_state_e;

endpackage

`default_nettype wire

/* pps/pps_generator.sv */
/*
 * Internal PPS generator
 * Counts one second of reference cycles and drives a fixed-width pulse.
 * A toggle of the adjust flag loads a phase offset at the next boundary.
 */

`default_nettype none

`include "ntps_defines.svh"

module pps_generator
  import ntps_pkg::*;
#(
  parameter int PPS_PERIOD = `NTPS_PPS_PERIOD,
  parameter int PPS_WIDTH  = `NTPS_PPS_WIDTH
) (
  input  wire             TEN_MHZ_INA,
  input  wire             rst_n,
  input  wire pps_count_t pps_adjust_value,
  input  wire logic       pps_adjust_toggle,
  output logic            internal_pps
);

  localparam pps_count_t SECOND_LAST = pps_count_t'(PPS_PERIOD - 1);
  localparam pps_count_t PULSE_END   = pps_count_t'(PPS_WIDTH);

  pps_count_t pps_ctr;
  logic       adjust_follow;
  logic       second_end;
  logic       adjust_pending;

  // Also catches an adjust value loaded past the end of the second
  assign second_end = (pps_ctr >= SECOND_LAST);

  // Flag toggled since the last adjust was taken
  assign adjust_pending = (adjust_follow != pps_adjust_toggle);

  // --------------------------------------------------
  // Second counter
  // --------------------------------------------------
  always_ff @(posedge TEN_MHZ_INA) begin
    if (!rst_n) begin
      pps_ctr       <= '0;
      adjust_follow <= 1'b0;
    end else begin
      if (!second_end) begin
        pps_ctr <= pps_ctr + 1'b1;
      end else if (adjust_pending) begin
        // One adjust per toggle
        pps_ctr       <= pps_adjust_value;
        adjust_follow <= pps_adjust_toggle;
      end else begin
        pps_ctr <= '0;
      end
    end
  end

  // --------------------------------------------------
  // Pulse output
  // --------------------------------------------------
  // Registered, so the pulse trails the counter by one cycle
  always_ff @(posedge TEN_MHZ_INA) begin
    if (!rst_n) begin
      internal_pps <= 1'b0;
    end else begin
      internal_pps <= (pps_ctr < PULSE_END);
    end
  end

endmodule

`default_nettype wire

/* beat/beat_link.sv */
/*
 * Beat link
 * Synchronises the external PPS and sends one short XGMII frame
 * per pulse. Also flags receive activity on the monitored path.
 */

`default_nettype none

`include "ntps_defines.svh"

module beat_link
  import ntps_pkg::*;
(
  input  wire              TEN_MHZ_INA,
  input  wire              rst_n,
  input  wire logic        pps_in,
  input  wire xgmii_ctrl_t rx_ctrl,
  output xgmii_data_t      txd,
  output xgmii_ctrl_t      txc,
  output logic             beat_send,
  output logic             beat_recv
);

  localparam beat_index_t FIRST_INDEX = beat_index_t'(`NTPS_BEAT_FIRST_INDEX);
  localparam beat_index_t LAST_INDEX  = beat_index_t'(`NTPS_BEAT_LAST_INDEX);

  logic        pps_meta;
  logic        pps_sync;
  beat_state_e beat_state;
  beat_index_t beat_index;

  // --------------------------------------------------
  // PPS synchroniser
  // --------------------------------------------------
  always_ff @(posedge TEN_MHZ_INA) begin
    if (!rst_n) begin
      pps_meta <= 1'b0;
      pps_sync <= 1'b0;
    end else begin
      pps_meta <= pps_in;
      pps_sync <= pps_meta;
    end
  end

  // --------------------------------------------------
  // Beat frame FSM
  // --------------------------------------------------
  // Outputs are registered per state, so a word leaves one cycle
  // after its state is entered
  always_ff @(posedge TEN_MHZ_INA) begin
    if (!rst_n) begin
      beat_state <= BEAT_IDLE;
      beat_index <= FIRST_INDEX;
      txd        <= `NTPS_XGMII_IDLE_WORD;
      txc        <= `NTPS_XGMII_CTRL_ALL;
      beat_send  <= 1'b0;
    end else begin
      case (beat_state)
        BEAT_IDLE: begin
          txd       <= `NTPS_XGMII_IDLE_WORD;
          txc       <= `NTPS_XGMII_CTRL_ALL;
          beat_send <= 1'b0;
          // A PPS still high here restarts after one idle word
          if (pps_sync) begin
            beat_state <= BEAT_START;
          end
        end
        BEAT_START: begin
          txd        <= `NTPS_XGMII_START_WORD;
          txc        <= `NTPS_XGMII_CTRL_START;
          beat_send  <= 1'b1;
          beat_index <= FIRST_INDEX;
          beat_state <= BEAT_DATA;
        end
        BEAT_DATA: begin
          txd        <= xgmii_data_t'(beat_index);
          txc        <= `NTPS_XGMII_CTRL_NONE;
          beat_send  <= 1'b1;
          beat_index <= beat_index + 1'b1;
          if (beat_index == LAST_INDEX) begin
            beat_state <= BEAT_TERM;
          end
        end
        BEAT_TERM: begin
          txd        <= `NTPS_XGMII_TERM_WORD;
          txc        <= `NTPS_XGMII_CTRL_ALL;
          beat_send  <= 1'b1;
          beat_state <= BEAT_IDLE;
        end
        default: begin
          beat_state <= BEAT_IDLE;
        end
      endcase
    end
  end

  // --------------------------------------------------
  // Receive activity
  // --------------------------------------------------
  // Any lane not control means traffic on the path
  always_ff @(posedge TEN_MHZ_INA) begin
    if (!rst_n) begin
      beat_recv <= 1'b0;
    end else begin
      beat_recv <= (rx_ctrl != `NTPS_XGMII_CTRL_ALL);
    end
  end

endmodule

`default_nettype wire

/* rtl/ntps_timing_top.sv */
/*
 * NTP server timing top level
 * Internal PPS generator and beat link on the 10 MHz reference,
 * with the beat frame copied onto every network path
 */

`default_nettype none

`include "ntps_defines.svh"

module ntps_timing_top
  import ntps_pkg::*;
#(
  parameter int NUM_PATHS  = `NTPS_NUM_PATHS,
  parameter int PPS_PERIOD = `NTPS_PPS_PERIOD,
  parameter int PPS_WIDTH  = `NTPS_PPS_WIDTH
) (
  input  wire              TEN_MHZ_INA,
  input  wire              rst_n,
  input  wire logic        pps_in,
  input  wire pps_count_t  pps_adjust_value,
  input  wire logic        pps_adjust_toggle,
  input  wire xgmii_ctrl_t xgmii_rxc [NUM_PATHS],
  output xgmii_data_t      xgmii_txd [NUM_PATHS],
  output xgmii_ctrl_t      xgmii_txc [NUM_PATHS],
  output logic             internal_pps,
  output logic             beat_send,
  output logic             beat_recv
);

  xgmii_data_t beat_txd;
  xgmii_ctrl_t beat_txc;

  // --------------------------------------------------
  // Internal PPS
  // --------------------------------------------------
  pps_generator #(
    .PPS_PERIOD (PPS_PERIOD),
    .PPS_WIDTH  (PPS_WIDTH)
  ) pps_generator_inst (
    .TEN_MHZ_INA       (TEN_MHZ_INA),
    .rst_n             (rst_n),
    .pps_adjust_value  (pps_adjust_value),
    .pps_adjust_toggle (pps_adjust_toggle),
    .internal_pps      (internal_pps)
  );

  // --------------------------------------------------
  // Beat frames
  // --------------------------------------------------
  // Receive activity is watched on the last path only
  beat_link beat_link_inst (
    .TEN_MHZ_INA (TEN_MHZ_INA),
    .rst_n       (rst_n),
    .pps_in      (pps_in),
    .rx_ctrl     (xgmii_rxc[NUM_PATHS-1]),
    .txd         (beat_txd),
    .txc         (beat_txc),
    .beat_send   (beat_send),
    .beat_recv   (beat_recv)
  );

  // Same frame on every path
  for (genvar path = 0; path < NUM_PATHS; path++) begin : gen_path_tx
    assign xgmii_txd[path] = beat_txd;
    assign xgmii_txc[path] = beat_txc;
  end

endmodule

`default_nettype wire

/* dv/tb_ntps_timing.sv */
/*
 * Testbench for the NTP server timing top level
 * A reference model of the PPS and beat frame rules runs beside the DUT
 * and concurrent assertions compare the two on every cycle
 */

`default_nettype none

`include "ntps_defines.svh"

module tb_ntps_timing
  import ntps_pkg::*;
();

  localparam int NUM_PATHS      = `NTPS_NUM_PATHS;
  localparam int PPS_PERIOD     = 200;
  localparam int PPS_WIDTH      = 10;
  localparam int RESET_CYCLES   = 8;
  localparam int TIMEOUT_CYCLES = 10 * PPS_PERIOD;
  // Start word, data words and terminate word
  localparam int FRAME_WORDS = `NTPS_BEAT_LAST_INDEX - `NTPS_BEAT_FIRST_INDEX + 3;

  logic        TEN_MHZ_INA;
  logic        rst_n;
  logic        pps_in;
  pps_count_t  pps_adjust_value;
  logic        pps_adjust_toggle;
  xgmii_ctrl_t xgmii_rxc [NUM_PATHS];
  xgmii_data_t xgmii_txd [NUM_PATHS];
  xgmii_ctrl_t xgmii_txc [NUM_PATHS];
  logic        internal_pps;
  logic        beat_send;
  logic        beat_recv;

  int error_count = 0;
  int cycle_count = 0;

  ntps_timing_top #(
    .NUM_PATHS  (NUM_PATHS),
    .PPS_PERIOD (PPS_PERIOD),
    .PPS_WIDTH  (PPS_WIDTH)
  ) ntps_timing_top_inst (
    .TEN_MHZ_INA       (TEN_MHZ_INA),
    .rst_n             (rst_n),
    .pps_in            (pps_in),
    .pps_adjust_value  (pps_adjust_value),
    .pps_adjust_toggle (pps_adjust_toggle),
    .xgmii_rxc         (xgmii_rxc),
    .xgmii_txd         (xgmii_txd),
    .xgmii_txc         (xgmii_txc),
    .internal_pps      (internal_pps),
    .beat_send         (beat_send),
    .beat_recv         (beat_recv)
  );

  initial begin
    TEN_MHZ_INA = 1'b0;
    forever #5 TEN_MHZ_INA = ~TEN_MHZ_INA;
  end

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  // Frame position 0 is idle, 1 the start word, FRAME_WORDS the terminate word
  function automatic xgmii_data_t frame_word(input int pos);
    if (pos == 0) return `NTPS_XGMII_IDLE_WORD;
    if (pos == 1) return `NTPS_XGMII_START_WORD;
    if (pos == FRAME_WORDS) return `NTPS_XGMII_TERM_WORD;
    return xgmii_data_t'(`NTPS_BEAT_FIRST_INDEX + pos - 2);
  endfunction

  function automatic xgmii_ctrl_t frame_ctrl(input int pos);
    if (pos == 0 || pos == FRAME_WORDS) return `NTPS_XGMII_CTRL_ALL;
    if (pos == 1) return `NTPS_XGMII_CTRL_START;
    return `NTPS_XGMII_CTRL_NONE;
  endfunction

  logic pps_prev, rise_seen, toggle_prev, adjust_pending;
  logic pps_d0, pps_d1, pps_d2, recv_exp;
  int   spacing_ctr, high_ctr, exp_spacing, exp_width, adjust_amount, exp_pos;
  int   spacing_checks, width_checks, adjust_hits, frame_count, recv_hits;
  logic pps_rise, pps_fall;
  xgmii_data_t exp_txd;
  xgmii_ctrl_t exp_txc;

  assign pps_rise = internal_pps && !pps_prev;
  assign pps_fall = !internal_pps && pps_prev;
  assign exp_txd  = frame_word(exp_pos);
  assign exp_txc  = frame_ctrl(exp_pos);

  always @(posedge TEN_MHZ_INA) begin
    if (!rst_n) begin
      pps_prev       <= 1'b0;
      rise_seen      <= 1'b0;
      toggle_prev    <= 1'b0;
      adjust_pending <= 1'b0;
      adjust_amount  <= 0;
      spacing_ctr    <= 0;
      high_ctr       <= 0;
      exp_spacing    <= PPS_PERIOD;
      exp_width      <= PPS_WIDTH;
      {pps_d0, pps_d1, pps_d2} <= 3'b000;
      exp_pos        <= 0;
      recv_exp       <= 1'b0;
      spacing_checks <= 0;
      width_checks   <= 0;
      adjust_hits    <= 0;
      frame_count    <= 0;
      recv_hits      <= 0;
    end else begin
      pps_prev <= internal_pps;
      high_ctr <= internal_pps ? high_ctr + 1 : 0;
      if (pps_rise) begin
        rise_seen   <= 1'b1;
        spacing_ctr <= 1;
        if (rise_seen) spacing_checks <= spacing_checks + 1;
        // A taken adjust moves this pulse and its second forward by the value
        if (adjust_pending) begin
          exp_width      <= PPS_WIDTH - adjust_amount;
          exp_spacing    <= PPS_PERIOD - adjust_amount;
          adjust_pending <= 1'b0;
          adjust_hits    <= adjust_hits + 1;
        end else begin
          exp_width   <= PPS_WIDTH;
          exp_spacing <= PPS_PERIOD;
        end
      end else begin
        spacing_ctr <= spacing_ctr + 1;
      end
      if (pps_fall) width_checks <= width_checks + 1;
      toggle_prev <= pps_adjust_toggle;
      if (pps_adjust_toggle != toggle_prev) begin
        adjust_pending <= 1'b1;
        adjust_amount  <= int'(pps_adjust_value);
      end

      // Start word three cycles after pps_in is sampled high, from idle only
      {pps_d2, pps_d1, pps_d0} <= {pps_d1, pps_d0, pps_in};
      if (exp_pos == 0) begin
        if (pps_d2) begin
          exp_pos     <= 1;
          frame_count <= frame_count + 1;
        end
      end else if (exp_pos == FRAME_WORDS) begin
        exp_pos <= 0;
      end else begin
        exp_pos <= exp_pos + 1;
      end
      recv_exp <= (xgmii_rxc[NUM_PATHS-1] != `NTPS_XGMII_CTRL_ALL);
      if (recv_exp) recv_hits <= recv_hits + 1;
    end
  end

  // --------------------------------------------------
  // Assertions
  // --------------------------------------------------
  pps_spacing_check: assert property (@(posedge TEN_MHZ_INA) disable iff (!rst_n)
    (pps_rise && rise_seen) |-> (spacing_ctr == exp_spacing))
    else begin
      error_count++;
      $display("Error at %0t: PPS spacing %0d cycles, expected %0d",
               $time, $sampled(spacing_ctr), $sampled(exp_spacing));
    end

  pps_width_check: assert property (@(posedge TEN_MHZ_INA) disable iff (!rst_n)
    pps_fall |-> (high_ctr == exp_width))
    else begin
      error_count++;
      $display("Error at %0t: PPS pulse %0d cycles, expected %0d",
               $time, $sampled(high_ctr), $sampled(exp_width));
    end

  beat_send_check: assert property (@(posedge TEN_MHZ_INA) disable iff (!rst_n)
    beat_send == (exp_pos != 0))
    else begin
      error_count++;
      $display("Error at %0t: beat_send is %0b at frame position %0d",
               $time, $sampled(beat_send), $sampled(exp_pos));
    end

  beat_recv_check: assert property (@(posedge TEN_MHZ_INA) disable iff (!rst_n)
    beat_recv == recv_exp)
    else begin
      error_count++;
      $display("Error at %0t: beat_recv is %0b, expected %0b",
               $time, $sampled(beat_recv), $sampled(recv_exp));
    end

  for (genvar p = 0; p < NUM_PATHS; p++) begin : gen_path_check
    tx_word_check: assert property (@(posedge TEN_MHZ_INA) disable iff (!rst_n)
      (xgmii_txd[p] == exp_txd) && (xgmii_txc[p] == exp_txc))
      else begin
        error_count++;
        $display("Error at %0t: path %0d sends %h/%h, expected %h/%h", $time, p,
                 $sampled(xgmii_txd[p]), $sampled(xgmii_txc[p]),
                 $sampled(exp_txd), $sampled(exp_txc));
      end
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  function automatic xgmii_ctrl_t random_active_ctrl();
    return xgmii_ctrl_t'($urandom_range(254, 0));
  endfunction

  // Holds pps_in high and returns once the given number of frames has ended
  task automatic drive_pps(input int high_cycles, input int frames);
    int   cycles;
    int   frames_done;
    logic send_prev;
    cycles      = 0;
    frames_done = 0;
    send_prev   = beat_send;
    pps_in      = 1'b1;
    while (frames_done < frames) begin
      @(negedge TEN_MHZ_INA);
      cycles++;
      if (cycles == high_cycles) pps_in = 1'b0;
      if (send_prev && !beat_send) frames_done++;
      send_prev = beat_send;
    end
    pps_in = 1'b0;
  endtask

  task automatic wait_pps_rises(input int rises);
    int   seen;
    logic pps_last;
    seen     = 0;
    pps_last = internal_pps;
    while (seen < rises) begin
      @(negedge TEN_MHZ_INA);
      if (internal_pps && !pps_last) seen++;
      pps_last = internal_pps;
    end
  endtask

  // Even cycles keep the last path idle while the others carry traffic
  task automatic drive_rx_activity(input int cycles);
    for (int c = 0; c < cycles; c++) begin
      @(negedge TEN_MHZ_INA);
      for (int p = 0; p < NUM_PATHS - 1; p++) xgmii_rxc[p] = random_active_ctrl();
      if (c % 2 == 0) xgmii_rxc[NUM_PATHS-1] = `NTPS_XGMII_CTRL_ALL;
      else xgmii_rxc[NUM_PATHS-1] = random_active_ctrl();
    end
    @(negedge TEN_MHZ_INA);
    for (int p = 0; p < NUM_PATHS; p++) xgmii_rxc[p] = `NTPS_XGMII_CTRL_ALL;
  endtask

  initial begin
    int adj_value;
    void'($urandom(32'h8b21));
    rst_n             = 1'b0;
    pps_in            = 1'b0;
    pps_adjust_value  = '0;
    pps_adjust_toggle = 1'b0;
    for (int p = 0; p < NUM_PATHS; p++) xgmii_rxc[p] = `NTPS_XGMII_CTRL_ALL;
    repeat (RESET_CYCLES) @(posedge TEN_MHZ_INA);
    @(negedge TEN_MHZ_INA);
    rst_n = 1'b1;

    // Idle stream after reset, then single frames and back-to-back frames
    repeat (20) @(negedge TEN_MHZ_INA);
    for (int n = 1; n <= 2; n++) begin
      drive_pps(n, 1);
      repeat (5) @(negedge TEN_MHZ_INA);
    end
    drive_pps(15, 2);
    repeat (5) @(negedge TEN_MHZ_INA);
    drive_rx_activity(40);
    repeat (5) @(negedge TEN_MHZ_INA);

    // Free-running seconds, then one phase adjust in mid-second
    wait_pps_rises(2);
    repeat (PPS_PERIOD / 4) @(negedge TEN_MHZ_INA);
    adj_value         = int'($urandom_range(PPS_WIDTH - 1, 1));
    pps_adjust_value  = pps_count_t'(adj_value);
    pps_adjust_toggle = ~pps_adjust_toggle;
    wait_pps_rises(3);
    repeat (PPS_WIDTH + 5) @(negedge TEN_MHZ_INA);

    if (spacing_checks < 4 || width_checks < 4 || adjust_hits != 1) begin
      error_count++;
      $display("The PPS checks were not all reached by the stimulus");
    end
    if (frame_count != 4 || recv_hits == 0) begin
      error_count++;
      $display("The beat frame or receive checks were not all reached by the stimulus");
    end
    $display("Checks: %0d spacings, %0d widths, %0d frames, %0d receive flags, %0d errors",
             spacing_checks, width_checks, frame_count, recv_hits, error_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  always @(posedge TEN_MHZ_INA) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+common
common/ntps_pkg.sv
pps/pps_generator.sv
beat/beat_link.sv
rtl/ntps_timing_top.sv
dv/tb_ntps_timing.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the NTP timing testbench with Verilator and runs it into a log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
  -f all.f \
  --top-module tb_ntps_timing \
  -Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "STATUS: FAIL" "$LOG_FILE"; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"
exit 0
